//--- common/cpu_pkg.sv
// ==================================================
// Pipeline types and encodings
// ==================================================
package cpu_pkg;

  typedef logic [31:0] word_t;     // Data, address or instruction
  typedef logic [4:0]  reg_idx_t;

  // Instruction class, bits 31:26
  //   R-type     rd = rs op rt
  //   addi       rd = rs + sext(imm)
  //   lw         rd = dmem[rs + sext(imm)]
  //   sw         dmem[rs + sext(imm)] = rd
  // Data addresses are word indices
  typedef enum logic [5:0] {
    op_nop  = 6'd0,
    op_add  = 6'd1,
    op_sub  = 6'd2,
    op_and  = 6'd3,
    op_or   = 6'd4,
    op_xor  = 6'd5,
    op_addi = 6'd6,
    op_lw   = 6'd7,
    op_sw   = 6'd8,
    op_halt = 6'd9
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add    = 5'd0,
    alu_sub    = 5'd1,
    alu_and    = 5'd2,
    alu_or     = 5'd3,
    alu_xor    = 5'd4,
    alu_pass_b = 5'd5
  } alu_op_e;

  localparam int opc_hi = 31;
  localparam int opc_lo = 26;
  localparam int rd_hi  = 25;
  localparam int rd_lo  = 21;
  localparam int rs_hi  = 20;
  localparam int rs_lo  = 16;
  localparam int rt_hi  = 15;  // Overlaps imm
  localparam int rt_lo  = 11;
  localparam int imm_hi = 15;
  localparam int imm_lo = 0;

  localparam word_t nop_instr = 32'h0000_0000;  // Opcode field is op_nop

endpackage

//--- decode/reg_file.sv
// ==================================================
// Register file
// ==================================================
`timescale 1ns/1ps

module reg_file (
  input  logic              rst,
  input  logic              arst_n,
  input  cpu_pkg::reg_idx_t ra1, ra2, ra3,
  output cpu_pkg::word_t    rd1, rd2, rd3,
  input  logic              we,
  input  cpu_pkg::reg_idx_t wa,
  input  cpu_pkg::word_t    wd
);

  cpu_pkg::word_t regs [32];

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd;  // r0 never written
    end
  end

  // Write-through so decode sees the writeback value in the same cycle
  assign rd1 = (we && wa == ra1 && ra1 != '0) ? wd : regs[ra1];
  assign rd2 = (we && wa == ra2 && ra2 != '0) ? wd : regs[ra2];
  assign rd3 = (we && wa == ra3 && ra3 != '0) ? wd : regs[ra3];

endmodule

//--- decode/decode_stage.sv
// ==================================================
// Instruction decode and load-use detect
// ==================================================
`timescale 1ns/1ps

module decode_stage (
  input  logic              rst,
  input  logic              arst_n,
  input  logic              f_valid,
  input  cpu_pkg::word_t    f_instr, f_pc,
  input  logic              ex_lw,
  input  cpu_pkg::reg_idx_t ex_rd,
  input  logic              w_wreg,
  input  cpu_pkg::reg_idx_t w_rd,
  input  cpu_pkg::word_t    w_data,
  input  cpu_pkg::reg_idx_t dbg_addr,
  output cpu_pkg::word_t    dbg_data,
  output logic              stall,
  output cpu_pkg::word_t    id_a, id_b, id_imm, id_pc, id_instr,
  output cpu_pkg::reg_idx_t id_rd, id_rs, id_rt,
  output cpu_pkg::alu_op_e  id_aluc,
  output logic              id_wreg, id_wmem, id_lw, id_halt
);

  cpu_pkg::word_t    d_instr;
  cpu_pkg::word_t    d_pc;
  cpu_pkg::opcode_e  op;
  cpu_pkg::reg_idx_t rd_idx, rs_idx, rt_idx;
  logic              r_type, uses_a, uses_b;

  // Fetch to decode register, frozen while stalled
  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      d_instr <= cpu_pkg::nop_instr;
      d_pc    <= '0;
    end else if (!stall) begin
      d_instr <= f_valid ? f_instr : cpu_pkg::nop_instr;
      if (f_valid) begin
        d_pc <= f_pc;
      end
    end
  end

  assign op     = cpu_pkg::opcode_e'(d_instr[cpu_pkg::opc_hi:cpu_pkg::opc_lo]);
  assign rd_idx = d_instr[cpu_pkg::rd_hi:cpu_pkg::rd_lo];
  assign rs_idx = d_instr[cpu_pkg::rs_hi:cpu_pkg::rs_lo];
  // sw takes its store data from the rd field
  assign rt_idx = (op == cpu_pkg::op_sw) ? rd_idx : d_instr[cpu_pkg::rt_hi:cpu_pkg::rt_lo];

  assign r_type = op inside {cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
                             cpu_pkg::op_or, cpu_pkg::op_xor};
  assign uses_a = r_type || (op inside {cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw});
  assign uses_b = r_type || (op == cpu_pkg::op_sw);

  assign id_wreg = (r_type || op == cpu_pkg::op_addi || op == cpu_pkg::op_lw) &&
                   (rd_idx != '0);  // r0 writes dropped here
  assign id_wmem = (op == cpu_pkg::op_sw);
  assign id_lw   = (op == cpu_pkg::op_lw);
  assign id_halt = (op == cpu_pkg::op_halt);

  always_comb begin
    case (op)
      cpu_pkg::op_sub:  id_aluc = cpu_pkg::alu_sub;
      cpu_pkg::op_and:  id_aluc = cpu_pkg::alu_and;
      cpu_pkg::op_or:   id_aluc = cpu_pkg::alu_or;
      cpu_pkg::op_xor:  id_aluc = cpu_pkg::alu_xor;
      cpu_pkg::op_nop,
      cpu_pkg::op_halt: id_aluc = cpu_pkg::alu_pass_b;
      default:          id_aluc = cpu_pkg::alu_add;  // add, addi, address calc
    endcase
  end

  // Load in EX feeding this instruction
  assign stall = ex_lw && (ex_rd != '0) &&
                 ((uses_a && ex_rd == rs_idx) || (uses_b && ex_rd == rt_idx));

  assign id_imm   = {{16{d_instr[cpu_pkg::imm_hi]}}, d_instr[cpu_pkg::imm_hi:cpu_pkg::imm_lo]};
  assign id_rd    = rd_idx;
  assign id_rs    = rs_idx;
  assign id_rt    = rt_idx;
  assign id_pc    = d_pc;
  assign id_instr = d_instr;

  reg_file u_rf (
    .rst    (rst),
    .arst_n (arst_n),
    .ra1    (rs_idx),
    .ra2    (rt_idx),
    .ra3    (dbg_addr),
    .rd1    (id_a),
    .rd2    (id_b),
    .rd3    (dbg_data),
    .we     (w_wreg),
    .wa     (w_rd),
    .wd     (w_data)
  );

endmodule

//--- verilog/fetch_stage.sv
// ==================================================
// Instruction fetch
// ==================================================
`timescale 1ns/1ps

module fetch_stage #(
  parameter int imem_aw = 8
) (
  input  logic                rst,
  input  logic                arst_n,
  input  logic                start,
  input  logic                stall,
  input  logic                prog_we,
  input  logic [imem_aw-1:0]  prog_addr,
  input  cpu_pkg::word_t      prog_data,
  output logic                f_valid,
  output cpu_pkg::word_t      f_instr,
  output cpu_pkg::word_t      f_pc
);

  cpu_pkg::word_t     imem [2**imem_aw];
  logic [imem_aw-1:0] pc;
  logic               run;
  cpu_pkg::word_t     rd_word;
  logic               is_halt;

  assign rd_word = imem[pc];
  assign is_halt = (rd_word[cpu_pkg::opc_hi:cpu_pkg::opc_lo] == cpu_pkg::op_halt);

  // Program load, only while idle
  always_ff @(posedge rst) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      pc      <= '0;
      run     <= 1'b0;
      f_valid <= 1'b0;
    end else if (start) begin
      pc      <= '0;
      run     <= 1'b1;
      f_valid <= 1'b0;
    end else if (!stall) begin
      f_valid <= run;
      if (run) begin
        pc <= pc + 1'b1;
        if (is_halt) begin
          run <= 1'b0;  // Nothing issued past halt
        end
      end
    end
  end

  // Registered RAM read
  always_ff @(posedge rst) begin
    if (run && !stall && !start) begin
      f_instr <= rd_word;
      f_pc    <= cpu_pkg::word_t'(pc);
    end
  end

endmodule

//--- verilog/id_ex_reg.sv
// ==================================================
// Decode to execute register
// ==================================================
`timescale 1ns/1ps

module id_ex_reg (
  input  logic              rst,
  input  logic              arst_n,
  input  logic              stall,
  input  cpu_pkg::word_t    id_a, id_b, id_imm, id_pc, id_instr,
  input  cpu_pkg::reg_idx_t id_rd, id_rs, id_rt,
  input  cpu_pkg::alu_op_e  id_aluc,
  input  logic              id_wreg, id_wmem, id_lw, id_halt,
  output cpu_pkg::word_t    ex_a, ex_b, ex_imm, ex_pc, ex_instr,
  output cpu_pkg::reg_idx_t ex_rd, ex_rs, ex_rt,
  output cpu_pkg::alu_op_e  ex_aluc,
  output logic              ex_wreg, ex_wmem, ex_lw, ex_halt
);

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      ex_a     <= '0;
      ex_b     <= '0;
      ex_imm   <= '0;
      ex_pc    <= '0;
      ex_instr <= cpu_pkg::nop_instr;
      ex_rd    <= '0;
      ex_rs    <= '0;
      ex_rt    <= '0;
      ex_aluc  <= cpu_pkg::alu_add;
      ex_wreg  <= 1'b0;
      ex_wmem  <= 1'b0;
      ex_lw    <= 1'b0;
      ex_halt  <= 1'b0;
    end else begin
      ex_a     <= id_a;
      ex_b     <= id_b;
      ex_imm   <= id_imm;
      ex_pc    <= id_pc;  // pc passes even for a bubble
      ex_rd    <= id_rd;
      ex_rs    <= id_rs;
      ex_rt    <= id_rt;
      // Bubble on stall
      ex_instr <= stall ? cpu_pkg::nop_instr : id_instr;
      ex_aluc  <= stall ? cpu_pkg::alu_add : id_aluc;
      ex_wreg  <= id_wreg && !stall;
      ex_wmem  <= id_wmem && !stall;
      ex_lw    <= id_lw && !stall;
      ex_halt  <= id_halt && !stall;
    end
  end

  a_reset_hold: assert property (@(posedge rst)
    !arst_n |-> (ex_instr == cpu_pkg::nop_instr && ex_pc == '0 &&
                 !ex_wreg && !ex_wmem && !ex_lw && !ex_halt))
    else $error("id_ex: reset state not held");

  // Same load must not reach EX twice
  a_stall_bubble: assert property (@(posedge rst) disable iff (!arst_n)
    stall |=> (ex_instr == cpu_pkg::nop_instr && ex_pc == $past(id_pc) &&
               !ex_wreg && !ex_wmem && !ex_lw && !ex_halt))
    else $error("id_ex: no bubble after stall");

  a_ctrl_follow: assert property (@(posedge rst) disable iff (!arst_n)
    !stall |=> ({ex_aluc, ex_wreg, ex_wmem, ex_lw, ex_halt} ==
                $past({id_aluc, id_wreg, id_wmem, id_lw, id_halt})))
    else $error("id_ex: control bits lost while running");

endmodule

//--- verilog/execute_stage.sv
// ==================================================
// Execute with operand forwarding
// ==================================================
`timescale 1ns/1ps

module execute_stage (
  input  logic              rst,
  input  logic              arst_n,
  input  cpu_pkg::word_t    ex_a, ex_b, ex_imm, ex_instr,
  input  cpu_pkg::reg_idx_t ex_rd, ex_rs, ex_rt,
  input  cpu_pkg::alu_op_e  ex_aluc,
  input  logic              ex_wreg, ex_wmem, ex_lw, ex_halt,
  input  logic              w_wreg,
  input  cpu_pkg::reg_idx_t w_rd,
  input  cpu_pkg::word_t    w_data,
  output cpu_pkg::word_t    m_alu, m_store,
  output cpu_pkg::reg_idx_t m_rd,
  output logic              m_wreg, m_wmem, m_lw, m_halt
);

  cpu_pkg::opcode_e op;
  logic             use_imm;
  cpu_pkg::word_t   opa, opb, alu_b, alu_y;

  assign op      = cpu_pkg::opcode_e'(ex_instr[cpu_pkg::opc_hi:cpu_pkg::opc_lo]);
  assign use_imm = op inside {cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw};

  // M result wins over writeback; a load in M only holds its address
  assign opa = (m_wreg && !m_lw && m_rd == ex_rs) ? m_alu :
               (w_wreg && w_rd == ex_rs)          ? w_data : ex_a;
  assign opb = (m_wreg && !m_lw && m_rd == ex_rt) ? m_alu :
               (w_wreg && w_rd == ex_rt)          ? w_data : ex_b;

  assign alu_b = use_imm ? ex_imm : opb;

  always_comb begin
    case (ex_aluc)
      cpu_pkg::alu_add: alu_y = opa + alu_b;
      cpu_pkg::alu_sub: alu_y = opa - alu_b;
      cpu_pkg::alu_and: alu_y = opa & alu_b;
      cpu_pkg::alu_or:  alu_y = opa | alu_b;
      cpu_pkg::alu_xor: alu_y = opa ^ alu_b;
      default:          alu_y = alu_b;
    endcase
  end

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      m_wreg <= 1'b0;
      m_wmem <= 1'b0;
      m_lw   <= 1'b0;
      m_halt <= 1'b0;
    end else begin
      m_wreg <= ex_wreg;
      m_wmem <= ex_wmem;
      m_lw   <= ex_lw;
      m_halt <= ex_halt;
    end
  end

  always_ff @(posedge rst) begin
    m_alu   <= alu_y;  // Address for lw and sw
    m_store <= opb;
    m_rd    <= ex_rd;
  end

  a_lw_xor_sw: assert property (@(posedge rst) disable iff (!arst_n)
    !(m_lw && m_wmem))
    else $error("execute: load and store flagged together");

endmodule

//--- verilog/mem_wb_stage.sv
// ==================================================
// Data memory and writeback
// ==================================================
`timescale 1ns/1ps

module mem_wb_stage #(
  parameter int dmem_aw = 8
) (
  input  logic              rst,
  input  logic              arst_n,
  input  cpu_pkg::word_t    m_alu, m_store,
  input  cpu_pkg::reg_idx_t m_rd,
  input  logic              m_wreg, m_wmem, m_lw, m_halt,
  output logic              w_wreg,
  output cpu_pkg::reg_idx_t w_rd,
  output cpu_pkg::word_t    w_data,
  output logic              retire_valid,
  output cpu_pkg::reg_idx_t retire_rd,
  output cpu_pkg::word_t    retire_data,
  output logic              done
);

  cpu_pkg::word_t     dmem [2**dmem_aw];
  logic [dmem_aw-1:0] addr;
  logic               w_halt;

  assign addr = m_alu[dmem_aw-1:0];  // Wraps at RAM depth

  always_ff @(posedge rst) begin
    if (m_wmem) begin
      dmem[addr] <= m_store;
    end
  end

  always_ff @(posedge rst or negedge arst_n) begin
    if (!arst_n) begin
      w_wreg <= 1'b0;
      w_halt <= 1'b0;
      done   <= 1'b0;
    end else begin
      w_wreg <= m_wreg;
      w_halt <= m_halt;
      done   <= w_halt;  // Halt leaving writeback
    end
  end

  always_ff @(posedge rst) begin
    w_rd   <= m_rd;
    w_data <= m_lw ? dmem[addr] : m_alu;
  end

  // Retire is the writeback bus itself
  assign retire_valid = w_wreg && (w_rd != '0);
  assign retire_rd    = w_rd;
  assign retire_data  = w_data;

endmodule

//--- verilog/cpu_top.sv
// ==================================================
// Five stage integer core
// ==================================================
`timescale 1ns/1ps

module cpu_top #(
  parameter int imem_aw = 8,
  parameter int dmem_aw = 8
) (
  input  logic               rst,
  input  logic               arst_n,
  input  logic               prog_we,
  input  logic [imem_aw-1:0] prog_addr,
  input  cpu_pkg::word_t     prog_data,
  input  logic               start,
  output logic               retire_valid,
  output cpu_pkg::reg_idx_t  retire_rd,
  output cpu_pkg::word_t     retire_data,
  output logic               done,
  input  cpu_pkg::reg_idx_t  dbg_addr,
  output cpu_pkg::word_t     dbg_data
);

  logic              stall;
  logic              f_valid;
  cpu_pkg::word_t    f_instr, f_pc;

  cpu_pkg::word_t    id_a, id_b, id_imm, id_pc, id_instr;
  cpu_pkg::reg_idx_t id_rd, id_rs, id_rt;
  cpu_pkg::alu_op_e  id_aluc;
  logic              id_wreg, id_wmem, id_lw, id_halt;

  cpu_pkg::word_t    ex_a, ex_b, ex_imm, ex_pc, ex_instr;
  cpu_pkg::reg_idx_t ex_rd, ex_rs, ex_rt;
  cpu_pkg::alu_op_e  ex_aluc;
  logic              ex_wreg, ex_wmem, ex_lw, ex_halt;

  cpu_pkg::word_t    m_alu, m_store;
  cpu_pkg::reg_idx_t m_rd;
  logic              m_wreg, m_wmem, m_lw, m_halt;

  // Writeback bus, also the forwarding source
  logic              w_wreg;
  cpu_pkg::reg_idx_t w_rd;
  cpu_pkg::word_t    w_data;

  fetch_stage #(.imem_aw(imem_aw)) u_fetch (.*);

  decode_stage u_decode (.*);

  id_ex_reg u_id_ex (.*);

  execute_stage u_execute (.*);

  mem_wb_stage #(.dmem_aw(dmem_aw)) u_mem_wb (.*);

endmodule

//--- verif/cpu_model.svh
// ==================================================
// ISA reference model
// ==================================================
`ifndef cpu_model_svh
`define cpu_model_svh

cpu_pkg::word_t    program_mem [prog_len];
cpu_pkg::word_t    model_regs [32];      // Final register image
cpu_pkg::word_t    model_dmem [dmem_depth];
logic              model_written [dmem_depth];
cpu_pkg::reg_idx_t exp_rd_q [$];         // Expected retires, program order
cpu_pkg::word_t    exp_data_q [$];

function automatic int rand_below(int n);
  return $unsigned($random(seed)) % n;
endfunction

// Mostly r0..r7 so neighbours depend on each other
function automatic cpu_pkg::reg_idx_t pick_reg();
  if (rand_below(4) != 0) begin
    return cpu_pkg::reg_idx_t'(rand_below(8));
  end
  return cpu_pkg::reg_idx_t'(rand_below(32));
endfunction

// r0 stays zero and never retires
function automatic void model_write(cpu_pkg::reg_idx_t rd, cpu_pkg::word_t val);
  if (rd != '0) begin
    model_regs[rd] = val;
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(val);
  end
endfunction

// Generates one instruction at a time and executes it at once
task automatic build_program();
  cpu_pkg::opcode_e  op;
  cpu_pkg::reg_idx_t rd, rs, rt;
  cpu_pkg::word_t    w, a, b, addr;
  logic [15:0]       imm;
  int                slot, sel;
  for (int i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < dmem_depth; i++) begin
    model_written[i] = 1'b0;
  end
  for (int i = 0; i < prog_len - 1; i++) begin
    sel = rand_below(16);
    rd  = pick_reg();
    rs  = pick_reg();
    rt  = pick_reg();
    case (sel)
      0, 1:      op = cpu_pkg::op_add;
      2:         op = cpu_pkg::op_sub;
      3:         op = cpu_pkg::op_and;
      4:         op = cpu_pkg::op_or;
      5:         op = cpu_pkg::op_xor;
      6, 7, 8:   op = cpu_pkg::op_addi;
      9, 10, 11: op = cpu_pkg::op_lw;
      12, 13:    op = cpu_pkg::op_sw;
      default:   op = cpu_pkg::op_nop;
    endcase
    // Loads only from a word stored earlier
    slot = -1;
    if (op == cpu_pkg::op_lw) begin
      sel = rand_below(16);
      for (int k = 0; k < 16; k++) begin
        if (slot < 0 && model_written[(sel + k) % 16]) begin
          slot = (sel + k) % 16;
        end
      end
      if (slot < 0) begin
        op = cpu_pkg::op_sw;
      end
    end
    if (op == cpu_pkg::op_sw) begin
      slot = rand_below(16);
    end
    if (slot >= 0) begin
      // Offset reaches the slot only after wrapping past the RAM depth
      a   = cpu_pkg::word_t'(slot) - model_regs[rs];
      imm = 16'((a % dmem_depth) + dmem_depth * rand_below(4));
    end else begin
      imm = 16'(rand_below(65536));
    end
    w = '0;
    w[cpu_pkg::opc_hi:cpu_pkg::opc_lo] = op;
    if (op != cpu_pkg::op_nop) begin
      w[cpu_pkg::rd_hi:cpu_pkg::rd_lo] = rd;
      w[cpu_pkg::rs_hi:cpu_pkg::rs_lo] = rs;
      if (op inside {cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw}) begin
        w[cpu_pkg::imm_hi:cpu_pkg::imm_lo] = imm;
      end else begin
        w[cpu_pkg::rt_hi:cpu_pkg::rt_lo] = rt;
      end
    end
    program_mem[i] = w;
    a    = model_regs[rs];
    b    = model_regs[rt];
    addr = a + {{16{imm[15]}}, imm};
    case (op)
      cpu_pkg::op_add:  model_write(rd, a + b);
      cpu_pkg::op_sub:  model_write(rd, a - b);
      cpu_pkg::op_and:  model_write(rd, a & b);
      cpu_pkg::op_or:   model_write(rd, a | b);
      cpu_pkg::op_xor:  model_write(rd, a ^ b);
      cpu_pkg::op_addi: model_write(rd, addr);
      cpu_pkg::op_lw:   model_write(rd, model_dmem[addr % dmem_depth]);
      cpu_pkg::op_sw: begin
        model_dmem[addr % dmem_depth]    = model_regs[rd];  // Store data in rd field
        model_written[addr % dmem_depth] = 1'b1;
      end
      default: ;
    endcase
  end
  w = '0;
  w[cpu_pkg::opc_hi:cpu_pkg::opc_lo] = cpu_pkg::op_halt;
  program_mem[prog_len - 1] = w;
endtask

`endif

//--- verif/cpu_tb.sv
// ==================================================
// Pipeline core testbench
// ==================================================
`timescale 1ns/1ps

module cpu_tb;

  localparam int imem_aw    = 8;
  localparam int dmem_aw    = 8;
  localparam int dmem_depth = 2**dmem_aw;
  localparam int prog_len   = 120;
  localparam int run_limit  = prog_len * 3 + 50;  // Cycles from start to done

  logic               rst;
  logic               arst_n;
  logic               prog_we;
  logic [imem_aw-1:0] prog_addr;
  cpu_pkg::word_t     prog_data;
  logic               start;
  logic               retire_valid;
  cpu_pkg::reg_idx_t  retire_rd;
  cpu_pkg::word_t     retire_data;
  logic               done;
  cpu_pkg::reg_idx_t  dbg_addr;
  cpu_pkg::word_t     dbg_data;

  integer seed = 32'hfe29;
  logic   started;
  int     done_count;

  `include "cpu_model.svh"

  cpu_top #(
    .imem_aw (imem_aw),
    .dmem_aw (dmem_aw)
  ) uut (
    .rst          (rst),
    .arst_n       (arst_n),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .start        (start),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .done         (done),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
  );

  initial begin
    rst = 1'b0;
    forever #10 rst = ~rst;
  end

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_retire(cpu_pkg::reg_idx_t rd, cpu_pkg::word_t data);
    cpu_pkg::reg_idx_t exp_rd;
    cpu_pkg::word_t    exp_data;
    if (exp_rd_q.size() == 0) begin
      stop_on_error($sformatf("Unexpected retire of r%0d at time %0t", rd, $time));
    end
    exp_rd   = exp_rd_q.pop_front();
    exp_data = exp_data_q.pop_front();
    if (rd !== exp_rd) begin
      stop_on_error($sformatf("Mismatch at time %0t: retire_rd expected %0d got %0d",
                              $time, exp_rd, rd));
    end
    if (data !== exp_data) begin
      stop_on_error($sformatf("Mismatch at time %0t: retire_data expected %h got %h",
                              $time, exp_data, data));
    end
  endtask

  task automatic check_reg(cpu_pkg::reg_idx_t idx, cpu_pkg::word_t got);
    if (got !== model_regs[idx]) begin
      stop_on_error($sformatf("Mismatch at time %0t: dbg_data[r%0d] expected %h got %h",
                              $time, idx, model_regs[idx], got));
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch at time %0t: %s expected %b got %b",
                              $time, name, exp, got));
    end
  endtask

  // Starts and ends 2 ns after a rising edge
  task automatic sweep_regs();
    for (int i = 0; i < 32; i++) begin
      dbg_addr = cpu_pkg::reg_idx_t'(i);
      @(negedge rst);
      check_reg(cpu_pkg::reg_idx_t'(i), dbg_data);
      check_flag("retire_valid", retire_valid, 1'b0);
      check_flag("done", done, 1'b0);
      @(posedge rst);
      #2;
    end
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_len; i++) begin
      prog_we   = 1'b1;
      prog_addr = imem_aw'(i);
      prog_data = program_mem[i];
      @(posedge rst);
      #2;
    end
    prog_we = 1'b0;
  endtask

  // Retire and done monitor, sampled mid cycle
  always @(negedge rst) begin
    if (retire_valid === 1'b1) begin
      check_retire(retire_rd, retire_data);
    end
    if (done === 1'b1) begin
      done_count++;
      if (!started) begin
        stop_on_error("done pulsed before the core was started");
      end
      if (exp_rd_q.size() != 0) begin
        stop_on_error($sformatf("done pulsed with %0d retires still expected",
                                exp_rd_q.size()));
      end
      if (done_count > 1) begin
        stop_on_error("done pulsed more than once");
      end
    end
  end

  initial begin
    wait (started);
    repeat (run_limit) @(posedge rst);
    if (done_count == 0) begin
      stop_on_error($sformatf("Timeout: core hung, no done within %0d cycles of start",
                              run_limit));
    end
  end

  initial begin
    arst_n     = 1'b0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    start      = 1'b0;
    dbg_addr   = '0;
    started    = 1'b0;
    done_count = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge rst);
    #2;
    arst_n = 1'b1;
    sweep_regs();  // All zero after reset
    build_program();
    load_program();
    start = 1'b1;
    @(posedge rst);
    #2;
    start   = 1'b0;
    started = 1'b1;
    wait (done_count == 1);
    repeat (5) @(posedge rst);  // Room for a stray retire or second done
    #2;
    sweep_regs();
    if (done_count == 1 && exp_rd_q.size() == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      stop_on_error("Run ended with retires missing or done count wrong");
    end
  end

endmodule

//--- filelist.f
+incdir+verif
common/cpu_pkg.sv
decode/reg_file.sv
decode/decode_stage.sv
verilog/fetch_stage.sv
verilog/id_ex_reg.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/cpu_top.sv
verif/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_pipeline

sources:
  - common/cpu_pkg.sv
  - decode/reg_file.sv
  - decode/decode_stage.sv
  - verilog/fetch_stage.sv
  - verilog/id_ex_reg.sv
  - verilog/execute_stage.sv
  - verilog/mem_wb_stage.sv
  - verilog/cpu_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/cpu_tb.sv
